//--- common/trg_pkg.sv
package trg_pkg;

  // sample and bus geometry
  localparam int adc_bits = 12;
  localparam int lane_bits = 16;
  localparam int samples_per_beat = 8;
  localparam int tdata_bits = 128;
  localparam int time_bits = 44;

  // window lengths, in valid beats
  localparam int post_len = 38;
  localparam int acqui_len = 100;
  localparam int count_bits = 7;

  // register port
  localparam int wb_data_bits = 32;

  typedef enum logic [1:0] {
    reg_threshold = 2'd0,
    reg_baseline  = 2'd1,
    reg_control   = 2'd2,
    reg_hit_count = 2'd3
  } wb_addr_e;

  // live trigger configuration
  typedef struct packed {
    logic signed [adc_bits:0]   threshold;
    logic signed [adc_bits-1:0] baseline;
    logic                       enable;
  } trg_cfg_t;

  // one beat as it moves between stages
  typedef struct packed {
    logic [tdata_bits-1:0] data;
    logic                  valid;
    logic                  hit;
    logic                  hit_rise;
    logic                  hit_fall;
    logic [time_bits-1:0]  time_stamp;
    trg_cfg_t              cfg;
  } beat_t;

  // stage 2 result
  typedef struct packed {
    beat_t beat;
    logic  triggered;
  } win_t;

  // record taken at the start of a hit run
  typedef struct packed {
    logic [time_bits-1:0]       time_stamp;
    logic signed [adc_bits-1:0] baseline;
    logic signed [adc_bits:0]   threshold;
  } event_t;

endpackage

//--- logic/trg_regs.sv
module trg_regs (
  input  logic                                AXIS_ACLK,
  input  logic                                hit_flag_negedge,
  input  logic                                wb_cyc,
  input  logic                                wb_stb,
  input  logic                                wb_we,
  input  trg_pkg::wb_addr_e                   wb_adr,
  input  logic [trg_pkg::wb_data_bits-1:0]    wb_dat_w,
  input  trg_pkg::win_t                       s2,
  output logic [trg_pkg::wb_data_bits-1:0]    wb_dat_r,
  output logic                                wb_ack,
  output trg_pkg::trg_cfg_t                   cfg
);

  logic signed [trg_pkg::adc_bits:0]   threshold;
  logic signed [trg_pkg::adc_bits-1:0] baseline;
  logic                                enable;
  logic [trg_pkg::wb_data_bits-1:0]    hit_cnt;
  logic                                wb_req;
  logic [trg_pkg::wb_data_bits-1:0]    rd_mux;

  // a request not yet answered
  assign wb_req = wb_cyc && wb_stb && !wb_ack;

  assign cfg.threshold = threshold;
  assign cfg.baseline  = baseline;
  assign cfg.enable    = enable;

  // signed fields go out as raw bits
  always_comb begin
    case (wb_adr)
      trg_pkg::reg_threshold:
        rd_mux = {{(trg_pkg::wb_data_bits - trg_pkg::adc_bits - 1){1'b0}}, threshold};
      trg_pkg::reg_baseline:
        rd_mux = {{(trg_pkg::wb_data_bits - trg_pkg::adc_bits){1'b0}}, baseline};
      trg_pkg::reg_control:
        rd_mux = {{(trg_pkg::wb_data_bits - 1){1'b0}}, enable};
      default:
        rd_mux = hit_cnt;
    endcase
  end

  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      wb_ack    <= 1'b0;
      threshold <= '0;
      baseline  <= '0;
      enable    <= 1'b0;
      hit_cnt   <= '0;
    end else begin
      wb_ack <= wb_req;
      // writes land on the edge that raises ack
      if (wb_req && wb_we) begin
        case (wb_adr)
          trg_pkg::reg_threshold: threshold <= wb_dat_w[trg_pkg::adc_bits:0];
          trg_pkg::reg_baseline:  baseline  <= wb_dat_w[trg_pkg::adc_bits-1:0];
          trg_pkg::reg_control:   enable    <= wb_dat_w[0];
          default: ;
        endcase
      end
      // one count per triggered run start, wraps
      if (s2.triggered && s2.beat.hit_rise) begin
        hit_cnt <= hit_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge AXIS_ACLK) begin
    if (wb_req) begin
      wb_dat_r <= rd_mux;
    end
  end

  // ack only ever answers a live request
  a_ack_after_req: assert property (
    @(posedge AXIS_ACLK) disable iff (hit_flag_negedge)
    wb_ack |-> $past(wb_cyc && wb_stb)
  );

endmodule

//--- trigger/hit_detect.sv
module hit_detect (
  input  logic                              AXIS_ACLK,
  input  logic                              hit_flag_negedge,
  input  logic [trg_pkg::tdata_bits-1:0]    s_tdata,
  input  logic                              s_tvalid,
  input  logic [trg_pkg::time_bits-1:0]     current_time,
  input  trg_pkg::trg_cfg_t                 cfg,
  output trg_pkg::beat_t                    s1
);

  logic signed [trg_pkg::adc_bits-1:0] sample [trg_pkg::samples_per_beat];
  logic signed [trg_pkg::adc_bits:0]   delta  [trg_pkg::samples_per_beat];
  logic [trg_pkg::samples_per_beat-1:0] above;
  logic                                 hit;
  logic                                 prev_hit;

  // sample sits in the upper 12 bits of each lane
  always_comb begin
    for (int i = 0; i < trg_pkg::samples_per_beat; i++) begin
      sample[i] = s_tdata[i*trg_pkg::lane_bits + trg_pkg::lane_bits-1 -: trg_pkg::adc_bits];
      delta[i]  = sample[i] - cfg.baseline;
      above[i]  = delta[i] >= cfg.threshold;
    end
  end

  assign hit = s_tvalid && cfg.enable && (|above);

  // previous-hit state follows valid beats only
  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      prev_hit <= 1'b0;
    end else if (s_tvalid) begin
      prev_hit <= hit;
    end
  end

  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      s1      <= '0;
      s1.data <= '1;
    end else begin
      s1.data       <= s_tdata;
      s1.valid      <= s_tvalid;
      s1.hit        <= hit;
      s1.hit_rise   <= hit && !prev_hit;
      s1.hit_fall   <= s_tvalid && !hit && prev_hit;
      // time and config in force at this beat
      s1.time_stamp <= current_time;
      s1.cfg        <= cfg;
    end
  end

endmodule

//--- trigger/trigger_window.sv
module trigger_window (
  input  logic           AXIS_ACLK,
  input  logic           hit_flag_negedge,
  input  trg_pkg::beat_t s1,
  output trg_pkg::win_t  s2
);

  logic [trg_pkg::count_bits-1:0] post_cnt;
  logic [trg_pkg::count_bits-1:0] post_nxt;
  logic [trg_pkg::count_bits-1:0] run_cnt;
  logic [trg_pkg::count_bits-1:0] run_nxt;
  logic                           fall_seen;
  logic                           fall_nxt;
  logic                           over_len;
  logic                           over_nxt;
  logic                           trig;

  // next state for this beat; idle cycles hold everything
  always_comb begin
    post_nxt = post_cnt;
    run_nxt  = run_cnt;
    fall_nxt = fall_seen;
    over_nxt = over_len;
    trig     = 1'b0;
    if (s1.valid) begin
      // trailing beats after the run ends
      if (s1.hit_fall) begin
        post_nxt = '0;
      end else if (post_cnt < trg_pkg::post_len) begin
        post_nxt = post_cnt + 1'b1;
      end

      // beats since the run started
      if (s1.hit_rise) begin
        run_nxt = '0;
      end else if (run_cnt < trg_pkg::acqui_len) begin
        run_nxt = run_cnt + 1'b1;
      end

      if (s1.hit_rise) begin
        fall_nxt = 1'b0;
      end else if (s1.hit_fall) begin
        fall_nxt = 1'b1;
      end

      // sticky until the next rise
      over_nxt = (over_len && !s1.hit_rise) || (run_nxt >= trg_pkg::acqui_len);

      trig = !over_nxt && (s1.hit || (fall_nxt && (post_nxt < trg_pkg::post_len)));
    end
  end

  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      post_cnt  <= '0;
      run_cnt   <= '0;
      fall_seen <= 1'b0;
      over_len  <= 1'b0;
    end else begin
      post_cnt  <= post_nxt;
      run_cnt   <= run_nxt;
      fall_seen <= fall_nxt;
      over_len  <= over_nxt;
    end
  end

  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      s2           <= '0;
      s2.beat.data <= '1;
    end else begin
      s2.beat      <= s1;
      s2.triggered <= trig;
    end
  end

  // no trigger on an idle cycle
  a_trig_valid: assert property (
    @(posedge AXIS_ACLK) disable iff (hit_flag_negedge)
    s2.triggered |-> s2.beat.valid
  );

endmodule

//--- trigger/hit_capture.sv
module hit_capture (
  input  logic                            AXIS_ACLK,
  input  logic                            hit_flag_negedge,
  input  trg_pkg::win_t                   s2,
  output logic [trg_pkg::tdata_bits-1:0]  m_tdata,
  output logic                            m_tvalid,
  output logic                            triggered,
  output trg_pkg::event_t                 hit_event,
  output logic                            event_valid
);

  trg_pkg::event_t fresh;
  trg_pkg::event_t event_q;

  assign m_tvalid    = s2.beat.valid;
  assign triggered   = s2.triggered;
  assign event_valid = s2.triggered && s2.beat.hit_rise;

  // valid lanes get the sample moved down and zero-extended
  // idle lanes pass as registered
  always_comb begin
    m_tdata = s2.beat.data;
    if (s2.beat.valid) begin
      for (int i = 0; i < trg_pkg::samples_per_beat; i++) begin
        m_tdata[i*trg_pkg::lane_bits +: trg_pkg::lane_bits] = {
          {(trg_pkg::lane_bits - trg_pkg::adc_bits){1'b0}},
          s2.beat.data[i*trg_pkg::lane_bits + trg_pkg::lane_bits-1 -: trg_pkg::adc_bits]
        };
      end
    end
  end

  always_comb begin
    fresh.time_stamp = s2.beat.time_stamp;
    fresh.baseline   = s2.beat.cfg.baseline;
    fresh.threshold  = s2.beat.cfg.threshold;
  end

  always_ff @(posedge AXIS_ACLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      event_q <= '0;
    end else if (event_valid) begin
      event_q <= fresh;
    end
  end

  // new record shows with its pulse, then holds
  assign hit_event = event_valid ? fresh : event_q;

  a_event_trig: assert property (
    @(posedge AXIS_ACLK) disable iff (hit_flag_negedge)
    event_valid |-> triggered
  );

endmodule

//--- logic/self_trigger_top.sv
module self_trigger_top (
  input  logic                              AXIS_ACLK,
  input  logic                              hit_flag_negedge,
  input  logic [trg_pkg::tdata_bits-1:0]    s_tdata,
  input  logic                              s_tvalid,
  input  logic [trg_pkg::time_bits-1:0]     current_time,
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  trg_pkg::wb_addr_e                 wb_adr,
  input  logic [trg_pkg::wb_data_bits-1:0]  wb_dat_w,
  output logic [trg_pkg::wb_data_bits-1:0]  wb_dat_r,
  output logic                              wb_ack,
  output logic [trg_pkg::tdata_bits-1:0]    m_tdata,
  output logic                              m_tvalid,
  output logic                              triggered,
  output trg_pkg::event_t                   hit_event,
  output logic                              event_valid
);

  trg_pkg::trg_cfg_t cfg;
  trg_pkg::beat_t    s1;
  trg_pkg::win_t     s2;

  trg_regs u_regs (
    .AXIS_ACLK        (AXIS_ACLK),
    .hit_flag_negedge (hit_flag_negedge),
    .wb_cyc           (wb_cyc),
    .wb_stb           (wb_stb),
    .wb_we            (wb_we),
    .wb_adr           (wb_adr),
    .wb_dat_w         (wb_dat_w),
    .s2               (s2),
    .wb_dat_r         (wb_dat_r),
    .wb_ack           (wb_ack),
    .cfg              (cfg)
  );

  // detect, window, capture
  hit_detect u_detect (
    .AXIS_ACLK        (AXIS_ACLK),
    .hit_flag_negedge (hit_flag_negedge),
    .s_tdata          (s_tdata),
    .s_tvalid         (s_tvalid),
    .current_time     (current_time),
    .cfg              (cfg),
    .s1               (s1)
  );

  trigger_window u_window (
    .AXIS_ACLK        (AXIS_ACLK),
    .hit_flag_negedge (hit_flag_negedge),
    .s1               (s1),
    .s2               (s2)
  );

  hit_capture u_capture (
    .AXIS_ACLK        (AXIS_ACLK),
    .hit_flag_negedge (hit_flag_negedge),
    .s2               (s2),
    .m_tdata          (m_tdata),
    .m_tvalid         (m_tvalid),
    .triggered        (triggered),
    .hit_event        (hit_event),
    .event_valid      (event_valid)
  );

endmodule

//--- bench/tb_self_trigger.sv
module tb_self_trigger;

  logic                               AXIS_ACLK;
  logic                               hit_flag_negedge;
  logic [trg_pkg::tdata_bits-1:0]     s_tdata;
  logic                               s_tvalid;
  logic [trg_pkg::time_bits-1:0]      current_time;
  logic                               wb_cyc;
  logic                               wb_stb;
  logic                               wb_we;
  trg_pkg::wb_addr_e                  wb_adr;
  logic [trg_pkg::wb_data_bits-1:0]   wb_dat_w;
  logic [trg_pkg::wb_data_bits-1:0]   wb_dat_r;
  logic                               wb_ack;
  logic [trg_pkg::tdata_bits-1:0]     m_tdata;
  logic                               m_tvalid;
  logic                               triggered;
  trg_pkg::event_t                    hit_event;
  logic                               event_valid;

  // expected output beats, oldest first
  logic [trg_pkg::tdata_bits-1:0]     exp_data_q [$];
  logic [1:0]                         exp_flag_q [$];
  trg_pkg::event_t                    exp_event_q [$];

  // register copies for the event record
  logic [trg_pkg::adc_bits:0]         thr_model;
  logic [trg_pkg::adc_bits-1:0]       base_model;
  logic [trg_pkg::adc_bits-1:0]       smp [trg_pkg::samples_per_beat];
  string                              test_name;
  int                                 tests;
  int                                 failed_tests;
  int                                 errors;

  self_trigger_top u_dut (.*);

  always #20 AXIS_ACLK = ~AXIS_ACLK;

  always @(negedge AXIS_ACLK) begin
    current_time <= current_time + 1'b1;
  end

  task automatic check(input string what, input logic [127:0] exp, input logic [127:0] act);
    assert (act === exp)
    else begin
      $display("error %s %s expected %0h actual %0h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic wb_access(input logic we, input logic [1:0] adr,
                           input logic [31:0] dat, output logic [31:0] rd);
    int n;
    @(negedge AXIS_ACLK);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = trg_pkg::wb_addr_e'(adr);
    wb_dat_w = dat;
    n = 0;
    do begin
      @(negedge AXIS_ACLK);
      n++;
    end while (!wb_ack && n < 50);
    if (!wb_ack) begin
      abort_run("timeout waiting for wb_ack");
    end else begin
      rd     = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
    end
  endtask

  // one beat after 0 to 2 idle cycles
  task automatic send_beat(input logic [1:0] flags);
    logic [trg_pkg::tdata_bits-1:0] din;
    logic [trg_pkg::tdata_bits-1:0] dout;
    trg_pkg::event_t                e;
    repeat ($urandom % 3) begin
      @(negedge AXIS_ACLK);
      s_tvalid = 1'b0;
    end
    @(negedge AXIS_ACLK);
    for (int i = 0; i < trg_pkg::samples_per_beat; i++) begin
      // low nibble is noise that the output drops
      din[i*16 +: 16]  = {smp[i], 4'($urandom)};
      dout[i*16 +: 16] = {4'h0, smp[i]};
    end
    s_tdata      = din;
    s_tvalid     = 1'b1;
    // the DUT takes the count due at the next rising edge
    e.time_stamp = current_time + 1'b1;
    e.baseline   = base_model;
    e.threshold  = thr_model;
    exp_data_q.push_back(dout);
    exp_flag_q.push_back(flags);
    exp_event_q.push_back(e);
  endtask

  task automatic drain_outputs();
    int n;
    n = 0;
    while (exp_data_q.size() != 0 && n < 50) begin
      @(negedge AXIS_ACLK);
      n++;
    end
    if (exp_data_q.size() != 0) begin
      abort_run("timeout waiting for m_tvalid");
    end
  endtask

  // each output beat against the oldest expected one
  always @(negedge AXIS_ACLK) begin : out_monitor
    logic [trg_pkg::tdata_bits-1:0] d;
    logic [1:0]                     f;
    trg_pkg::event_t                e;
    if (!hit_flag_negedge && m_tvalid) begin
      if (exp_data_q.size() == 0) begin
        $display("%s output beat arrived that was never sent", test_name);
        errors++;
      end else begin
        d = exp_data_q.pop_front();
        f = exp_flag_q.pop_front();
        e = exp_event_q.pop_front();
        check("m_tdata", d, m_tdata);
        check("triggered", f[1], triggered);
        check("event_valid", f[0], event_valid);
        // output shows one rising edge after the stamp
        check("latency", e.time_stamp + 1, current_time);
        if (f[0]) begin
          check("hit_event", e, hit_event);
        end
      end
    end
  end

  initial begin : stim_main
    int          fd;
    int          code;
    int          c;
    int          count;
    int          trig;
    int          ev;
    int          err_before;
    bit          done;
    logic [7:0]  cmd;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [31:0] rd;
    AXIS_ACLK        = 1'b0;
    hit_flag_negedge = 1'b1;
    s_tdata          = '0;
    s_tvalid         = 1'b0;
    current_time     = '0;
    wb_cyc           = 1'b0;
    wb_stb           = 1'b0;
    wb_we            = 1'b0;
    wb_adr           = trg_pkg::reg_threshold;
    wb_dat_w         = '0;
    thr_model        = '0;
    base_model       = '0;
    tests            = 0;
    failed_tests     = 0;
    errors           = 0;
    done             = 1'b0;
    c = $urandom(32'h400f);
    repeat (5) @(posedge AXIS_ACLK);
    @(negedge AXIS_ACLK);
    hit_flag_negedge = 1'b0;
    fd = $fopen("bench/self_trigger_stim.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open bench/self_trigger_stim.txt");
    end else begin
      while (!done) begin
        code = $fscanf(fd, " %c", cmd);
        if (code != 1) begin
          done = 1'b1;
        end else if (cmd == "#") begin
          c = $fgetc(fd);
          while (c != "\n" && c != -1) begin
            c = $fgetc(fd);
          end
        end else begin
          tests++;
          test_name  = $sformatf("test %0d (%c)", tests, cmd);
          err_before = errors;
          case (cmd)
            "W": begin
              code = $fscanf(fd, "%h %h", adr, dat);
              wb_access(1'b1, adr[1:0], dat, rd);
              if (adr[1:0] == 2'd0) begin
                thr_model = dat[trg_pkg::adc_bits:0];
              end else if (adr[1:0] == 2'd1) begin
                base_model = dat[trg_pkg::adc_bits-1:0];
              end
            end
            "R": begin
              code = $fscanf(fd, "%h %h", adr, dat);
              wb_access(1'b0, adr[1:0], '0, rd);
              check("wb_dat_r", dat, rd);
            end
            "B": begin
              code = $fscanf(fd, "%d %h %h %h %h %h %h %h %h %d %d", count,
                             smp[0], smp[1], smp[2], smp[3],
                             smp[4], smp[5], smp[6], smp[7], trig, ev);
              repeat (count) send_beat({trig[0], ev[0]});
              @(negedge AXIS_ACLK);
              s_tvalid = 1'b0;
              drain_outputs();
            end
            default: abort_run("unknown command in stimulus file");
          endcase
          if (errors == err_before) begin
            $display("%s passed", test_name);
          end else begin
            failed_tests++;
            $display("%s failed", test_name);
          end
        end
      end
      $fclose(fd);
      $display("%0d tests, %0d failed, %0d check errors", tests, failed_tests, errors);
      if (errors == 0) begin
        $display("Test OK");
      end else begin
        $display("Test FAILED");
      end
      $finish;
    end
  end

endmodule

//--- bench/self_trigger_stim.txt
# values hex except count, triggered and event, which are decimal
# W addr data / R addr expected / B count s0 s1 s2 s3 s4 s5 s6 s7 triggered event
R 3 0
R 0 0
R 2 0
W 0 1FF6
R 0 1FF6
W 1 FFFFFF9C
R 1 F9C
W 0 32
W 1 64
W 2 3
R 0 32
R 1 64
R 2 1
# baseline 100 and threshold 50
B 4 095 095 095 095 095 095 095 095 0 0
B 1 095 095 095 096 095 095 095 095 1 1
B 1 096 095 095 095 095 095 095 095 1 0
B 1 095 095 095 095 095 095 095 096 1 0
B 38 095 095 095 095 095 095 095 095 1 0
B 1 095 095 095 095 095 095 095 095 0 0
W 2 0
B 2 096 096 096 096 096 096 096 096 0 0
W 2 1
# baseline 80 and threshold 40
W 1 50
W 0 28
B 1 078 078 078 078 078 078 078 078 1 1
B 99 078 078 078 078 078 078 078 078 1 0
B 20 078 078 078 078 078 078 078 078 0 0
B 3 077 077 077 077 077 077 077 077 0 0
B 1 077 077 077 077 077 078 077 077 1 1
B 38 077 077 077 077 077 077 077 077 1 0
B 1 077 077 077 077 077 077 077 077 0 0
R 3 3

//--- self_trigger_top.f
common/trg_pkg.sv
logic/trg_regs.sv
trigger/hit_detect.sv
trigger/trigger_window.sv
trigger/hit_capture.sv
logic/self_trigger_top.sv
bench/tb_self_trigger.sv
